/* source/spi_rx_macros.svh */
`ifndef SPI_RX_MACROS_SVH
`define SPI_RX_MACROS_SVH

//##########################################################################
// frame field widths
//##########################################################################

// first field of every frame
`define SPI_OPCODE_W 8

// repeated until cs rises
`define SPI_DATA_W 16

//##########################################################################
// clock crossing FIFO sizes
//##########################################################################

`define SPI_OPC_FIFO_AW 2 // depth 4
`define SPI_DAT_FIFO_AW 3 // depth 8

`endif

/* source/spi_rx_pkg.sv */
package spi_rx_pkg;

    //######################################################################
    // deserializer frame phase
    //######################################################################

    // cs high always forces the phase back to OPCODE_PHASE
    typedef enum logic {
        OPCODE_PHASE = 1'b0, // collecting the leading opcode bits
        DATA_PHASE   = 1'b1  // collecting data words until cs rises
    } spi_frame_state_e;

    //######################################################################
    // FIFO status
    //######################################################################

    // full and overflow come from the write clock domain,
    // empty comes from the read clock domain
    typedef struct packed {
        logic full;     // write side sees no free entry
        logic empty;    // read side has no word at the head
        logic overflow; // sticky, a write was dropped while full
    } fifo_flags_t;

endpackage

/* source/spi_deserializer.sv */
`include "spi_rx_macros.svh"

module spi_deserializer import spi_rx_pkg::*; (
    input  logic                     clk_spi,
    input  logic                     rstb,
    input  logic                     cs,
    input  logic                     spi_mosi,
    output logic                     wr_opcode,
    output logic [`SPI_OPCODE_W-1:0] opcode_word,
    output logic                     wr_data,
    output logic [`SPI_DATA_W-1:0]   data_word
);

    localparam int CNT_W = $clog2(`SPI_DATA_W);

    logic [`SPI_DATA_W-1:0] shift_reg;
    logic [`SPI_DATA_W-1:0] shift_next;
    logic [CNT_W-1:0]       bit_cnt;
    spi_frame_state_e       phase;
    logic                   opcode_done;
    logic                   word_done;

    //######################################################################
    // bit sampling
    //######################################################################

    // one shift register serves both phases, the opcode is its low byte
    assign shift_next = {shift_reg[`SPI_DATA_W-2:0], spi_mosi};

    // the edge that samples the last bit of the current item
    assign opcode_done = !cs && (phase == OPCODE_PHASE) &&
                         (bit_cnt == CNT_W'(`SPI_OPCODE_W - 1));
    assign word_done   = !cs && (phase == DATA_PHASE) &&
                         (bit_cnt == CNT_W'(`SPI_DATA_W - 1));

    //######################################################################
    // frame control
    //######################################################################

    always_ff @(posedge clk_spi or negedge rstb) begin
        if (!rstb) begin
            bit_cnt   <= '0;
            phase     <= OPCODE_PHASE;
            wr_opcode <= 1'b0;
            wr_data   <= 1'b0;
        end else begin
            wr_opcode <= opcode_done; // one cycle, after the 8th opcode bit
            wr_data   <= word_done;   // one cycle, after the 16th word bit

            if (cs) begin
                phase   <= OPCODE_PHASE; // any partial item is abandoned here
                bit_cnt <= '0;
            end else if (opcode_done) begin
                phase   <= DATA_PHASE;
                bit_cnt <= '0;
            end else if (word_done) begin
                bit_cnt <= '0; // stay in data phase for the next word
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    //######################################################################
    // payload
    //######################################################################

    always_ff @(posedge clk_spi) begin
        if (!cs) begin
            shift_reg <= shift_next;
        end

        // words are captured together with their strobe
        if (opcode_done) begin
            opcode_word <= shift_next[`SPI_OPCODE_W-1:0];
        end

        if (word_done) begin
            data_word <= shift_next;
        end
    end

endmodule

/* source/async_fifo.sv */
module async_fifo import spi_rx_pkg::*; #(
    parameter int WIDTH  = 8,
    parameter int ADDR_W = 2
) (
    input  logic             wr_clk,
    input  logic             rstb,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_clk,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output fifo_flags_t      flags
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [WIDTH-1:0] mem [DEPTH];

    // write domain
    logic [ADDR_W:0] wr_bin;
    logic [ADDR_W:0] wr_gray;
    logic [ADDR_W:0] wr_bin_next;
    logic [ADDR_W:0] wr_gray_next;
    logic [ADDR_W:0] rd_gray_meta;
    logic [ADDR_W:0] rd_gray_sync;
    logic            wr_accept;
    logic            full_q;
    logic            overflow_q;

    // read domain
    logic [ADDR_W:0] rd_bin;
    logic [ADDR_W:0] rd_gray;
    logic [ADDR_W:0] rd_bin_next;
    logic [ADDR_W:0] rd_gray_next;
    logic [ADDR_W:0] wr_gray_meta;
    logic [ADDR_W:0] wr_gray_sync;
    logic            rd_accept;
    logic            empty_q;

    //######################################################################
    // write side
    //######################################################################

    assign wr_accept    = wr_en && !full_q; // a write while full is dropped
    assign wr_bin_next  = wr_bin + (ADDR_W + 1)'(wr_accept);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    always_ff @(posedge wr_clk or negedge rstb) begin
        if (!rstb) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    always_ff @(posedge wr_clk or negedge rstb) begin
        if (!rstb) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            full_q     <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
            // full when the write pointer has lapped the read pointer once
            full_q  <= (wr_gray_next == {~rd_gray_sync[ADDR_W:ADDR_W-1],
                                         rd_gray_sync[ADDR_W-2:0]});
            if (wr_en && full_q) begin
                overflow_q <= 1'b1; // held until the next reset
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_accept) begin
            mem[wr_bin[ADDR_W-1:0]] <= din;
        end
    end

    //######################################################################
    // read side
    //######################################################################

    assign rd_accept    = rd_en && !empty_q; // a pop while empty is ignored
    assign rd_bin_next  = rd_bin + (ADDR_W + 1)'(rd_accept);
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    always_ff @(posedge rd_clk or negedge rstb) begin
        if (!rstb) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    always_ff @(posedge rd_clk or negedge rstb) begin
        if (!rstb) begin
            rd_bin  <= '0;
            rd_gray <= '0;
            empty_q <= 1'b1;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
            empty_q <= (rd_gray_next == wr_gray_sync);
        end
    end

    // head word is always on the output, valid while empty is low
    assign dout = mem[rd_bin[ADDR_W-1:0]];

    always_comb begin
        flags.full     = full_q;
        flags.empty    = empty_q;
        flags.overflow = overflow_q;
    end

endmodule

/* source/spi_rx_top.sv */
`include "spi_rx_macros.svh"

module spi_rx_top import spi_rx_pkg::*; (
    input  logic                     clk_spi,
    input  logic                     clk_sys,
    input  logic                     rstb,
    input  logic                     cs,
    input  logic                     spi_mosi,
    input  logic                     rd_opcode,
    input  logic                     rd_data,
    output logic [`SPI_OPCODE_W-1:0] opcode_out,
    output logic [`SPI_DATA_W-1:0]   data_out,
    output fifo_flags_t              opcode_flags,
    output fifo_flags_t              data_flags
);

    logic                     wr_opcode;
    logic [`SPI_OPCODE_W-1:0] opcode_word;
    logic                     wr_data;
    logic [`SPI_DATA_W-1:0]   data_word;

    //######################################################################
    // serial clock domain
    //######################################################################

    spi_deserializer u_deser (
        .clk_spi     (clk_spi),
        .rstb        (rstb),
        .cs          (cs),
        .spi_mosi    (spi_mosi),
        .wr_opcode   (wr_opcode),
        .opcode_word (opcode_word),
        .wr_data     (wr_data),
        .data_word   (data_word)
    );

    //######################################################################
    // crossing into clk_sys
    //######################################################################

    async_fifo #(
        .WIDTH  (`SPI_OPCODE_W),
        .ADDR_W (`SPI_OPC_FIFO_AW)
    ) u_opcode_fifo (
        .wr_clk (clk_spi),
        .rstb   (rstb),
        .wr_en  (wr_opcode),
        .din    (opcode_word),
        .rd_clk (clk_sys),
        .rd_en  (rd_opcode),
        .dout   (opcode_out),
        .flags  (opcode_flags)
    );

    async_fifo #(
        .WIDTH  (`SPI_DATA_W),
        .ADDR_W (`SPI_DAT_FIFO_AW)
    ) u_data_fifo (
        .wr_clk (clk_spi),
        .rstb   (rstb),
        .wr_en  (wr_data),
        .din    (data_word),
        .rd_clk (clk_sys),
        .rd_en  (rd_data),
        .dout   (data_out),
        .flags  (data_flags)
    );

endmodule

/* bench/spi_rx_checker.sv */
`include "spi_rx_macros.svh"

module spi_rx_checker import spi_rx_pkg::*; (
    input  logic                     clk_spi,
    input  logic                     clk_sys,
    input  logic                     rd_opcode,
    input  logic                     rd_data,
    input  logic [`SPI_OPCODE_W-1:0] opcode_out,
    input  logic [`SPI_DATA_W-1:0]   data_out,
    input  fifo_flags_t              opcode_flags,
    input  fifo_flags_t              data_flags,
    input  int                       test_idx,
    input  logic                     frame_start,
    input  logic                     check_full,
    input  logic                     test_done,
    output int                       pass_count,
    output int                       fail_count,
    output logic                     done
);

    localparam int MAX_T = 16;

    string                    names [MAX_T];
    int                       opbits [MAX_T];
    logic [`SPI_OPCODE_W-1:0] opcode [MAX_T];
    int                       nwords [MAX_T];
    logic [`SPI_DATA_W-1:0]   words [MAX_T][10];
    int                       policy [MAX_T];
    int                       bad [MAX_T];
    int                       n_tests = 0;
    int                       reported = 0;

    logic [`SPI_OPCODE_W-1:0] exp_opc[$];
    int                       own_opc[$];
    logic [`SPI_DATA_W-1:0]   exp_dat[$];
    int                       own_dat[$];
    int                       pend_opc = 0; // words held in each FIFO with pops deferred
    int                       pend_dat = 0;
    logic                     ovf_opc = 1'b0;
    logic                     ovf_dat = 1'b0;

    initial begin
        int    fd;
        int    n;
        int    t;
        string line;
        string nm;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        for (t = 0; t < MAX_T; t++) begin
            bad[t] = 0;
        end
        fd = $fopen("bench/spi_rx_golden.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open the golden file");
            fail_count = 1;
        end else begin
            while (!$feof(fd) && n_tests < MAX_T) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                t = n_tests;
                n = $sscanf(line, "%s %d %h %d %h %h %h %h %h %h %h %h %h %h %d %d",
                            nm, opbits[t], opcode[t], nwords[t], words[t][0], words[t][1],
                            words[t][2], words[t][3], words[t][4], words[t][5],
                            words[t][6], words[t][7], words[t][8], words[t][9],
                            n, policy[t]);
                names[t] = nm;
                n_tests++;
            end
            $fclose(fd);
        end
    end

    //##########################################################################
    // expected words, from the framing and FIFO depth rules
    //##########################################################################

    always @(posedge clk_spi) begin
        int          j;
        fifo_flags_t exp_oflags;
        fifo_flags_t exp_dflags;
        if (frame_start) begin
            if (test_idx == 0) begin
                if (opcode_flags !== 3'b010 || data_flags !== 3'b010) begin
                    $display("Fail reset_state: flags expected 010 010 actual %b %b",
                             opcode_flags, data_flags);
                    fail_count++;
                end else begin
                    $display("test reset_state ok");
                    pass_count++;
                end
            end
            if (opbits[test_idx] == `SPI_OPCODE_W) begin // a cut opcode leaves nothing
                if (policy[test_idx] == 0 || pend_opc < (1 << `SPI_OPC_FIFO_AW)) begin
                    exp_opc.push_back(opcode[test_idx]);
                    own_opc.push_back(test_idx);
                    if (policy[test_idx] != 0) pend_opc++;
                end else begin
                    ovf_opc = 1'b1;
                end
                for (j = 0; j < nwords[test_idx]; j++) begin
                    if (policy[test_idx] == 0 || pend_dat < (1 << `SPI_DAT_FIFO_AW)) begin
                        exp_dat.push_back(words[test_idx][j]);
                        own_dat.push_back(test_idx);
                        if (policy[test_idx] != 0) pend_dat++;
                    end else begin
                        ovf_dat = 1'b1; // the rest of the frame is dropped
                    end
                end
            end
        end
        if (check_full) begin
            exp_dflags.full     = (pend_dat == (1 << `SPI_DAT_FIFO_AW));
            exp_dflags.empty    = (pend_dat == 0);
            exp_dflags.overflow = ovf_dat;
            exp_oflags.full     = (pend_opc == (1 << `SPI_OPC_FIFO_AW));
            exp_oflags.empty    = (pend_opc == 0);
            exp_oflags.overflow = ovf_opc;
            if (data_flags !== exp_dflags) begin
                $display("Fail %s: data flags expected %b actual %b", names[test_idx],
                         exp_dflags, data_flags);
                bad[test_idx]++;
            end
            if (opcode_flags !== exp_oflags) begin
                $display("Fail %s: opcode flags expected %b actual %b", names[test_idx],
                         exp_oflags, opcode_flags);
                bad[test_idx]++;
            end
        end
        if (test_done && policy[test_idx] != 2) begin
            while (exp_opc.size() > 0) begin
                $display("%s: opcode 0x%02h never came out", names[own_opc[0]], exp_opc[0]);
                bad[own_opc.pop_front()]++;
                void'(exp_opc.pop_front());
            end
            while (exp_dat.size() > 0) begin
                $display("%s: data word 0x%04h never came out", names[own_dat[0]], exp_dat[0]);
                bad[own_dat.pop_front()]++;
                void'(exp_dat.pop_front());
            end
            if (opcode_flags.full !== 1'b0 || data_flags.full !== 1'b0) begin
                $display("%s: a FIFO still reports full after draining", names[test_idx]);
                bad[test_idx]++;
            end
            if (opcode_flags.overflow !== ovf_opc || data_flags.overflow !== ovf_dat) begin
                $display("Fail %s: overflow expected %0b %0b actual %0b %0b", names[test_idx],
                         ovf_opc, ovf_dat, opcode_flags.overflow, data_flags.overflow);
                bad[test_idx]++;
            end
            pend_opc = 0;
            pend_dat = 0;
            for (j = reported; j <= test_idx; j++) begin
                if (bad[j] == 0) begin
                    $display("test %s ok", names[j]);
                    pass_count++;
                end else begin
                    $display("test %s has %0d errors", names[j], bad[j]);
                    fail_count++;
                end
            end
            reported = test_idx + 1;
            if (test_idx == n_tests - 1) begin
                $display("results: %0d ok, %0d with errors", pass_count, fail_count);
                done = 1'b1;
            end
        end
    end

    //##########################################################################
    // popped words
    //##########################################################################

    always @(posedge clk_sys) begin
        if (rd_opcode && !opcode_flags.empty) begin
            if (exp_opc.size() == 0) begin
                $display("%s: an opcode came out that no frame should leave", names[test_idx]);
                bad[test_idx]++;
            end else begin
                if (opcode_out !== exp_opc[0]) begin
                    $display("Fail %s: opcode expected 0x%02h actual 0x%02h",
                             names[own_opc[0]], exp_opc[0], opcode_out);
                    bad[own_opc[0]]++;
                end
                void'(exp_opc.pop_front());
                void'(own_opc.pop_front());
            end
        end
        if (rd_data && !data_flags.empty) begin
            if (exp_dat.size() == 0) begin
                $display("%s: a data word came out that no frame should leave", names[test_idx]);
                bad[test_idx]++;
            end else begin
                if (data_out !== exp_dat[0]) begin
                    $display("Fail %s: data expected 0x%04h actual 0x%04h",
                             names[own_dat[0]], exp_dat[0], data_out);
                    bad[own_dat[0]]++;
                end
                void'(exp_dat.pop_front());
                void'(own_dat.pop_front());
            end
        end
    end

endmodule

/* bench/spi_rx_tb.sv */
`include "spi_rx_macros.svh"

module spi_rx_tb import spi_rx_pkg::*; ();

    localparam int MAX_T = 16;

    logic                     clk_spi = 1'b0;
    logic                     clk_sys = 1'b0;
    logic                     rstb = 1'b0;
    logic                     cs = 1'b1;
    logic                     spi_mosi = 1'b0;
    logic                     rd_opcode = 1'b0;
    logic                     rd_data = 1'b0;
    logic [`SPI_OPCODE_W-1:0] opcode_out;
    logic [`SPI_DATA_W-1:0]   data_out;
    fifo_flags_t              opcode_flags;
    fifo_flags_t              data_flags;

    logic pop_en = 1'b0;
    logic frame_start = 1'b0;
    logic check_full = 1'b0;
    logic test_done = 1'b0;
    int   test_idx = 0;
    int   pass_count;
    int   fail_count;
    logic done;
    int   cycle_cnt = 0;
    int   limit = 0;

    int                       n_tests = 0;
    int                       opbits [MAX_T];
    logic [`SPI_OPCODE_W-1:0] opcode [MAX_T];
    int                       nwords [MAX_T];
    logic [`SPI_DATA_W-1:0]   words [MAX_T][10];
    int                       cut [MAX_T];
    int                       policy [MAX_T];

    spi_rx_top dut (.*);

    spi_rx_checker u_checker (.*);

    initial forever #4 clk_spi = ~clk_spi;
    initial forever #5 clk_sys = ~clk_sys; // unrelated to clk_spi

    //##########################################################################
    // stimulus
    //##########################################################################

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        string nm;
        fd = $fopen("bench/spi_rx_golden.txt", "r");
        while (fd != 0 && !$feof(fd) && n_tests < MAX_T) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %d %h %d %h %h %h %h %h %h %h %h %h %h %d %d",
                        nm, opbits[n_tests], opcode[n_tests], nwords[n_tests],
                        words[n_tests][0], words[n_tests][1], words[n_tests][2],
                        words[n_tests][3], words[n_tests][4], words[n_tests][5],
                        words[n_tests][6], words[n_tests][7], words[n_tests][8],
                        words[n_tests][9], cut[n_tests], policy[n_tests]);
            limit += opbits[n_tests] + 16 * nwords[n_tests] + cut[n_tests] + 4 + 50;
            n_tests++;
        end
        if (fd != 0) $fclose(fd);
    endtask

    task automatic drive_bit(input logic b);
        @(negedge clk_spi);
        cs       = 1'b0;
        spi_mosi = b;
    endtask

    task automatic send_frame(input int t);
        int j;
        int k;
        for (k = 0; k < opbits[t]; k++) drive_bit(opcode[t][`SPI_OPCODE_W-1-k]); // msb first
        if (opbits[t] == `SPI_OPCODE_W) begin
            for (j = 0; j < nwords[t]; j++) begin
                for (k = 0; k < `SPI_DATA_W; k++) drive_bit(words[t][j][`SPI_DATA_W-1-k]);
            end
            for (k = 0; k < cut[t]; k++) drive_bit(1'($urandom));
        end
        @(negedge clk_spi);
        cs       = 1'b1;
        spi_mosi = 1'b0;
    endtask

    task automatic wait_drained();
        int stable;
        stable = 0;
        while (stable < 8) begin
            @(negedge clk_sys);
            stable = (opcode_flags.empty && data_flags.empty) ? stable + 1 : 0;
        end
    endtask

    // pops only while the head word is valid, with random gaps
    always @(negedge clk_sys) begin
        rd_opcode <= pop_en && !opcode_flags.empty && ($urandom % 4 != 0);
        rd_data   <= pop_en && !data_flags.empty && ($urandom % 4 != 0);
    end

    always @(posedge clk_spi) begin
        cycle_cnt++;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("timeout after %0d clk_spi cycles, the run did not finish", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int t;
        void'($urandom(54));
        load_tests();
        limit += 20; // reset and start up
        repeat (3) @(posedge clk_spi);
        @(negedge clk_spi);
        rstb = 1'b1;
        for (t = 0; t < n_tests; t++) begin
            repeat (1 + $urandom % 4) @(negedge clk_spi); // idle gap between frames
            test_idx    = t;
            frame_start = 1'b1;
            @(negedge clk_spi);
            frame_start = 1'b0;
            pop_en      = (policy[t] == 0);
            send_frame(t);
            repeat (6) @(negedge clk_spi);
            if (policy[t] == 1) begin
                check_full = 1'b1;
                @(negedge clk_spi);
                check_full = 1'b0;
                pop_en     = 1'b1;
            end
            if (policy[t] != 2) begin
                wait_drained();
                pop_en = 1'b0;
                @(negedge clk_spi);
                test_done = 1'b1;
                @(negedge clk_spi);
                test_done = 1'b0;
            end
        end
        wait (done);
        @(negedge clk_spi);
        if (fail_count == 0 && pass_count == n_tests + 1) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/spi_rx_pkg.sv
source/spi_deserializer.sv
source/async_fifo.sv
source/spi_rx_top.sv
bench/spi_rx_checker.sv
bench/spi_rx_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := spi_rx_tb
FILE_LIST  := files.f
FLAGS      := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported errors"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/spi_rx_golden.txt */
# name opbits opcode nwords w0 w1 w2 w3 w4 w5 w6 w7 w8 w9 cut pop
# opbits < 8 cuts the opcode, cut = extra bits after the last word, pop 0 during 1 after 2 later
single_frame 8 a5 1 1234 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0
multi_word 8 3c 5 beef 0001 8000 7ffe c3a5 0000 0000 0000 0000 0000 0 0
cut_word 8 71 2 0f0f f0f0 0000 0000 0000 0000 0000 0000 0000 0000 9 0
after_cut 8 e2 1 5a5a 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0
cut_opcode 5 d8 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0
after_cut_op 8 4b 2 1357 2468 0000 0000 0000 0000 0000 0000 0000 0000 0 0
overflow 8 99 10 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa 0 1
b2b_1 8 01 2 0101 0102 0000 0000 0000 0000 0000 0000 0000 0000 0 2
b2b_2 8 02 3 0201 0202 0203 0000 0000 0000 0000 0000 0000 0000 0 2
b2b_3 8 03 1 0301 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 2
b2b_4 8 04 2 0401 0402 0000 0000 0000 0000 0000 0000 0000 0000 0 1
